/* sim.f */
+incdir+src
src/riscv_pkg.sv
src/riscv_hzrd_if.sv
src/riscv_decoder.sv
src/riscv_stage_regs.sv
src/riscv_muldiv_timer.sv
src/riscv_hazardunit.sv
src/riscv_fwd_mux.sv
src/riscv_pipectrl_top.sv
bench/riscv_pipectrl_checker.sv
bench/riscv_pipectrl_tb.sv

/* Makefile */
TOP := riscv_pipectrl_tb
SRC := sim.f $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): $(SRC)
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* bench/riscv_pipectrl_tb.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_pipectrl_tb;

  localparam int N_INSTR = 2000;
  // each instruction takes at most the mul/div latency, plus reset and drain
  localparam int MAX_CYC = N_INSTR * (`RISCV_MULDIV_LAT + 2) + 40;

  logic                   i_clk;
  logic                   i_rst_n;
  logic [31:0]            i_instr;
  logic                   i_instr_valid;
  logic                   i_pcsrc;
  logic [`RISCV_XLEN-1:0] i_rs1_data;
  logic [`RISCV_XLEN-1:0] i_rs2_data;
  logic [`RISCV_XLEN-1:0] i_alu_m;
  logic [`RISCV_XLEN-1:0] i_uimm_m;
  logic [`RISCV_XLEN-1:0] i_result_w;
  logic [`RISCV_XLEN-1:0] o_opa;
  logic [`RISCV_XLEN-1:0] o_opb;
  logic [1:0]             o_fwda;
  logic [1:0]             o_fwdb;
  logic                   o_stallpc;
  logic                   o_stallfd;
  logic                   o_flushfd;
  logic                   o_flushde;
  logic                   o_stall_muldiv;
  logic                   o_muldiv_valid;
  int                     err_cnt;
  int                     cyc_cnt;
  int                     issued;
  logic                   hold;
  logic [31:0]            lcg_state;

  riscv_pipectrl_top riscv_pipectrl_top_inst (.*);

  riscv_pipectrl_checker chk_inst (
    .i_opa          (o_opa),
    .i_opb          (o_opb),
    .i_fwda         (o_fwda),
    .i_fwdb         (o_fwdb),
    .i_stallpc      (o_stallpc),
    .i_stallfd      (o_stallfd),
    .i_flushfd      (o_flushfd),
    .i_flushde      (o_flushde),
    .i_stall_muldiv (o_stall_muldiv),
    .i_muldiv_valid (o_muldiv_valid),
    .o_err_cnt      (err_cnt),
    .o_cyc_cnt      (cyc_cnt),
    .*
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    lcg_state = lcg_step(lcg_state);
    r         = lcg_state;
  endtask

  // registers x0..x3 only, so hazards come often
  task automatic make_instr(output logic [31:0] w);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    next_rand(r);
    rd  = {3'b000, r[17:16]};
    rs1 = {3'b000, r[19:18]};
    rs2 = {3'b000, r[21:20]};
    case (r[26:24])
      3'd0:    w = {r[15:0], 4'h0, rd, riscv_pkg::OPC_LUI};
      3'd1:    w = {r[11:0], rs1, 3'b010, rd, riscv_pkg::OPC_LOAD};
      3'd2:    w = {7'b0000000, rs2, rs1, r[14:12], rd, riscv_pkg::OPC_OP};
      3'd3:    w = {r[11:0], rs1, 3'b000, rd, riscv_pkg::OPC_OPIMM};
      3'd4:    w = {r[6:0], rs2, rs1, 3'b010, r[11:7], riscv_pkg::OPC_STORE};
      3'd5:    w = {r[6:0], rs2, rs1, 3'b000, r[11:7], riscv_pkg::OPC_BRANCH};
      default: w = {7'b0000001, rs2, rs1, r[14:12], rd, riscv_pkg::OPC_OP};  // mul/div
    endcase
  endtask

  initial
  begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial
  begin
    #(MAX_CYC * 10);
    $display("timeout, stimulus did not complete within %0d cycles", MAX_CYC);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin : stimulus
    logic [31:0] r;
    lcg_state     = 32'd76;
    i_rst_n       = 1'b0;
    i_instr       = '0;
    i_instr_valid = 1'b0;
    i_pcsrc       = 1'b0;
    i_rs1_data    = '0;
    i_rs2_data    = '0;
    i_alu_m       = '0;
    i_uimm_m      = '0;
    i_result_w    = '0;
    hold          = 1'b0;
    issued        = 0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    repeat (4) @(negedge i_clk);  // empty pipe, no branch
    while (issued < N_INSTR)
    begin
      if (!hold)
      begin
        make_instr(i_instr);
        next_rand(r);
        i_instr_valid = (r[31:28] != 4'h0);
      end
      next_rand(r);
      i_pcsrc = (r[31:29] == 3'b000);
      next_rand(i_rs1_data);
      next_rand(i_rs2_data);
      next_rand(i_alu_m);
      next_rand(i_uimm_m);
      next_rand(i_result_w);
      @(posedge i_clk);
      hold = o_stallfd;  // decode holds, keep the same word
      if (!o_stallfd)
        issued++;
      @(negedge i_clk);
    end
    i_instr_valid = 1'b0;
    i_pcsrc       = 1'b0;
    repeat (`RISCV_MULDIV_LAT + 4) @(negedge i_clk);
    $display("%0d errors in %0d checked cycles, %0d instructions", err_cnt, cyc_cnt, issued);
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* bench/riscv_pipectrl_checker.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_pipectrl_checker (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic [31:0]            i_instr,
  input  logic                   i_instr_valid,
  input  logic                   i_pcsrc,
  input  logic [`RISCV_XLEN-1:0] i_rs1_data,
  input  logic [`RISCV_XLEN-1:0] i_rs2_data,
  input  logic [`RISCV_XLEN-1:0] i_alu_m,
  input  logic [`RISCV_XLEN-1:0] i_uimm_m,
  input  logic [`RISCV_XLEN-1:0] i_result_w,
  input  logic [`RISCV_XLEN-1:0] i_opa,
  input  logic [`RISCV_XLEN-1:0] i_opb,
  input  logic [1:0]             i_fwda,
  input  logic [1:0]             i_fwdb,
  input  logic                   i_stallpc,
  input  logic                   i_stallfd,
  input  logic                   i_flushfd,
  input  logic                   i_flushde,
  input  logic                   i_stall_muldiv,
  input  logic                   i_muldiv_valid,
  output int                     o_err_cnt,
  output int                     o_cyc_cnt
);

  riscv_pkg::stage_ctrl_t e_q;  // expected execute contents
  riscv_pkg::stage_ctrl_t m_q;
  riscv_pkg::stage_ctrl_t w_q;
  int                     md_age;  // cycles the mul/div has spent in execute
  int                     stall_run;
  int                     err_cnt = 0;
  int                     cyc_cnt = 0;

  assign o_err_cnt = err_cnt;
  assign o_cyc_cnt = cyc_cnt;

  function automatic riscv_pkg::stage_ctrl_t decode_word(input logic [31:0] w);
    riscv_pkg::stage_ctrl_t c;
    logic [6:0]             op;
    op = w[6:0];
    c  = '0;
    if (op inside {riscv_pkg::OPC_LUI, riscv_pkg::OPC_LOAD, riscv_pkg::OPC_OP,
                   riscv_pkg::OPC_OPIMM, riscv_pkg::OPC_STORE, riscv_pkg::OPC_BRANCH})
    begin
      c.opcode = op;
      c.regw   = op inside {riscv_pkg::OPC_LUI, riscv_pkg::OPC_LOAD, riscv_pkg::OPC_OP,
                            riscv_pkg::OPC_OPIMM};
      c.rd     = c.regw ? w[11:7] : '0;
      c.rs1    = (op == riscv_pkg::OPC_LUI) ? '0 : w[19:15];
      c.rs2    = (op inside {riscv_pkg::OPC_OP, riscv_pkg::OPC_STORE, riscv_pkg::OPC_BRANCH}) ?
                 w[24:20] : '0;
      c.resultsrc = (op == riscv_pkg::OPC_LOAD) ? riscv_pkg::RES_MEM : riscv_pkg::RES_ALU;
      c.mul_en = (op == riscv_pkg::OPC_OP) && (w[31:25] == 7'b0000001);  // mul and div alike
    end
    return c;
  endfunction

  function automatic logic [1:0] expected_fwd(input logic [`RISCV_REGADDR_W-1:0] rs);
    logic [1:0] sel;
    sel = riscv_pkg::FWD_RF;
    if (w_q.regw && (w_q.rd != '0) && (w_q.rd == rs))
      sel = riscv_pkg::FWD_W;
    if (m_q.regw && (m_q.rd != '0) && (m_q.rd == rs))  // memory stage overrides writeback
      sel = (m_q.opcode == riscv_pkg::OPC_LUI) ? riscv_pkg::FWD_M_UIMM : riscv_pkg::FWD_M_ALU;
    return sel;
  endfunction

  function automatic logic [`RISCV_XLEN-1:0] expected_op(input logic [1:0] sel,
                                                        input logic [`RISCV_XLEN-1:0] rf);
    case (sel)
      2'd1:    return i_result_w;
      2'd2:    return i_alu_m;
      2'd3:    return i_uimm_m;
      default: return rf;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v)
    begin
      err_cnt++;
      $display("Fail %s at %0t: expected %0h, actual %0h", name, $time, exp_v, act_v);
    end
  endtask

  always @(posedge i_clk)
  begin : model_step
    riscv_pkg::stage_ctrl_t d;
    logic [1:0]             fa;
    logic [1:0]             fb;
    logic                   valid_x;
    logic                   md_stall;
    logic                   load_use;
    if (!i_rst_n)
    begin
      e_q       = '0;
      m_q       = '0;
      w_q       = '0;
      md_age    = 0;
      stall_run = 0;
    end
    else
    begin
      d        = i_instr_valid ? decode_word(i_instr) : '0;
      fa       = expected_fwd(e_q.rs1);
      fb       = expected_fwd(e_q.rs2);
      valid_x  = (e_q.mul_en || e_q.div_en) && (md_age == `RISCV_MULDIV_LAT - 1);
      md_stall = (e_q.mul_en || e_q.div_en) && !valid_x;
      load_use = (e_q.resultsrc == riscv_pkg::RES_MEM) && (e_q.rd != '0) &&
                 ((d.rs1 == e_q.rd) || (d.rs2 == e_q.rd));
      check_value("fwda", 32'(fa), 32'(i_fwda));
      check_value("fwdb", 32'(fb), 32'(i_fwdb));
      check_value("opa", expected_op(fa, i_rs1_data), i_opa);
      check_value("opb", expected_op(fb, i_rs2_data), i_opb);
      check_value("stallpc", 32'(load_use || md_stall), 32'(i_stallpc));
      check_value("stallfd", 32'(load_use || md_stall), 32'(i_stallfd));
      check_value("flushfd", 32'(i_pcsrc), 32'(i_flushfd));
      check_value("flushde", 32'(load_use || i_pcsrc), 32'(i_flushde));
      check_value("stall_muldiv", 32'(md_stall), 32'(i_stall_muldiv));
      check_value("muldiv_valid", 32'(valid_x), 32'(i_muldiv_valid));
      if (i_stall_muldiv)
        stall_run++;
      else if (stall_run != 0)
      begin
        if ((stall_run != `RISCV_MULDIV_LAT - 1) || !i_muldiv_valid)
        begin
          err_cnt++;
          $display("mul/div stall ending at %0t lasted %0d cycles or ended without valid",
                   $time, stall_run);
        end
        stall_run = 0;
      end
      if (md_stall)
        md_age++;  // whole pipe frozen
      else
      begin
        md_age = 0;
        w_q    = m_q;
        m_q    = e_q;
        e_q    = (load_use || i_pcsrc) ? '0 : d;  // bubble on load-use or branch
      end
      cyc_cnt++;
    end
  end

endmodule

/* src/riscv_pipectrl_top.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_pipectrl_top (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic [31:0]            i_instr,
  input  logic                   i_instr_valid,
  input  logic                   i_pcsrc,
  input  logic [`RISCV_XLEN-1:0] i_rs1_data,
  input  logic [`RISCV_XLEN-1:0] i_rs2_data,
  input  logic [`RISCV_XLEN-1:0] i_alu_m,
  input  logic [`RISCV_XLEN-1:0] i_uimm_m,
  input  logic [`RISCV_XLEN-1:0] i_result_w,
  output logic [`RISCV_XLEN-1:0] o_opa,
  output logic [`RISCV_XLEN-1:0] o_opb,
  output logic [1:0]             o_fwda,
  output logic [1:0]             o_fwdb,
  output logic                   o_stallpc,
  output logic                   o_stallfd,
  output logic                   o_flushfd,
  output logic                   o_flushde,
  output logic                   o_stall_muldiv,
  output logic                   o_muldiv_valid
);

  riscv_pkg::stage_ctrl_t ctrl_d;
  riscv_pkg::stage_ctrl_t ctrl_e;
  riscv_pkg::stage_ctrl_t ctrl_m;
  riscv_pkg::stage_ctrl_t ctrl_w;
  riscv_pkg::fwdsel_e     fwda;
  riscv_pkg::fwdsel_e     fwdb;
  logic                   muldiv_valid;

  riscv_hzrd_if hzrd ();

  riscv_decoder riscv_decoder_inst (
    .i_instr       (i_instr),
    .i_instr_valid (i_instr_valid),
    .o_ctrl        (ctrl_d)
  );

  riscv_stage_regs riscv_stage_regs_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_ctrl_d (ctrl_d),
    .hzrd     (hzrd.stage),
    .o_ctrl_e (ctrl_e),
    .o_ctrl_m (ctrl_m),
    .o_ctrl_w (ctrl_w)
  );

  riscv_muldiv_timer riscv_muldiv_timer_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_ctrl_e (ctrl_e),
    .o_valid  (muldiv_valid)
  );

  riscv_hazardunit riscv_hazardunit_inst (
    .i_ctrl_d       (ctrl_d),
    .i_ctrl_e       (ctrl_e),
    .i_ctrl_m       (ctrl_m),
    .i_ctrl_w       (ctrl_w),
    .i_pcsrc        (i_pcsrc),
    .i_muldiv_valid (muldiv_valid),
    .o_fwda         (fwda),
    .o_fwdb         (fwdb),
    .hzrd           (hzrd.ctrl)
  );

  riscv_fwd_mux riscv_fwd_mux_inst (
    .i_fwda     (fwda),
    .i_fwdb     (fwdb),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .i_alu_m    (i_alu_m),
    .i_uimm_m   (i_uimm_m),
    .i_result_w (i_result_w),
    .o_opa      (o_opa),
    .o_opb      (o_opb)
  );

  assign o_fwda         = fwda;
  assign o_fwdb         = fwdb;
  assign o_stallpc      = hzrd.stallpc;
  assign o_stallfd      = hzrd.stallfd;
  assign o_flushfd      = hzrd.flushfd;
  assign o_flushde      = hzrd.flushde;
  assign o_stall_muldiv = hzrd.stallmw;  // all stage stalls move together
  assign o_muldiv_valid = muldiv_valid;

endmodule

/* src/riscv_fwd_mux.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_fwd_mux (
  input  riscv_pkg::fwdsel_e     i_fwda,
  input  riscv_pkg::fwdsel_e     i_fwdb,
  input  logic [`RISCV_XLEN-1:0] i_rs1_data,
  input  logic [`RISCV_XLEN-1:0] i_rs2_data,
  input  logic [`RISCV_XLEN-1:0] i_alu_m,
  input  logic [`RISCV_XLEN-1:0] i_uimm_m,
  input  logic [`RISCV_XLEN-1:0] i_result_w,
  output logic [`RISCV_XLEN-1:0] o_opa,
  output logic [`RISCV_XLEN-1:0] o_opb
);

  function automatic logic [`RISCV_XLEN-1:0] pick(
    input riscv_pkg::fwdsel_e     sel,
    input logic [`RISCV_XLEN-1:0] rf
  );
    case (sel)
      riscv_pkg::FWD_W:      return i_result_w;
      riscv_pkg::FWD_M_ALU:  return i_alu_m;
      riscv_pkg::FWD_M_UIMM: return i_uimm_m;
      default:               return rf;  // register file read
    endcase
  endfunction

  always_comb
  begin
    o_opa = pick(i_fwda, i_rs1_data);
    o_opb = pick(i_fwdb, i_rs2_data);
  end

endmodule

/* src/riscv_hazardunit.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_hazardunit (
  input  riscv_pkg::stage_ctrl_t i_ctrl_d,
  input  riscv_pkg::stage_ctrl_t i_ctrl_e,
  input  riscv_pkg::stage_ctrl_t i_ctrl_m,
  input  riscv_pkg::stage_ctrl_t i_ctrl_w,
  input  logic                   i_pcsrc,
  input  logic                   i_muldiv_valid,
  output riscv_pkg::fwdsel_e     o_fwda,
  output riscv_pkg::fwdsel_e     o_fwdb,
  riscv_hzrd_if.ctrl             hzrd
);

  logic m_stall;
  logic load_use;

  // memory stage beats writeback, x0 never forwarded
  function automatic riscv_pkg::fwdsel_e fwd_sel(
    input logic [`RISCV_REGADDR_W-1:0] rs,
    input riscv_pkg::stage_ctrl_t      m,
    input riscv_pkg::stage_ctrl_t      w
  );
    if ((rs == m.rd) && m.regw && (m.rd != '0) && (m.opcode == riscv_pkg::OPC_LUI))
      return riscv_pkg::FWD_M_UIMM;
    else if ((rs == m.rd) && m.regw && (m.rd != '0))
      return riscv_pkg::FWD_M_ALU;
    else if ((rs == w.rd) && w.regw && (w.rd != '0))
      return riscv_pkg::FWD_W;
    else
      return riscv_pkg::FWD_RF;
  endfunction

  always_comb
  begin
    o_fwda = fwd_sel(i_ctrl_e.rs1, i_ctrl_m, i_ctrl_w);
    o_fwdb = fwd_sel(i_ctrl_e.rs2, i_ctrl_m, i_ctrl_w);
  end

  assign m_stall = (i_ctrl_e.mul_en || i_ctrl_e.div_en) && !i_muldiv_valid;

  // load in execute feeding the instruction in decode
  assign load_use = (i_ctrl_e.resultsrc == riscv_pkg::RES_MEM) && (i_ctrl_e.rd != '0) &&
                    ((i_ctrl_d.rs1 == i_ctrl_e.rd) || (i_ctrl_d.rs2 == i_ctrl_e.rd));

  assign hzrd.stallpc = load_use || m_stall;
  assign hzrd.stallfd = load_use || m_stall;
  assign hzrd.flushfd = i_pcsrc;
  assign hzrd.flushde = load_use || i_pcsrc;  // bubble into execute

  // mul/div freezes every stage until valid
  assign hzrd.stallde = m_stall;
  assign hzrd.stallem = m_stall;
  assign hzrd.stallmw = m_stall;

endmodule

/* src/riscv_muldiv_timer.sv */
`timescale 1ns/1ps
`include "riscv_cfg.svh"

module riscv_muldiv_timer (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  riscv_pkg::stage_ctrl_t i_ctrl_e,
  output logic                   o_valid
);

  localparam int CNT_W = $clog2(`RISCV_MULDIV_LAT) + 1;

  logic             busy;
  logic [CNT_W-1:0] cnt;  // cycles already spent in execute

  assign busy    = i_ctrl_e.mul_en || i_ctrl_e.div_en;
  assign o_valid = busy && (cnt == CNT_W'(`RISCV_MULDIV_LAT - 1));

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      cnt <= '0;
    else if (o_valid || !busy)
      cnt <= '0;  // op leaves execute, next one starts fresh
    else
      cnt <= cnt + 1'b1;
  end

  // relies on the stage registers holding the op in execute
  a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (busy && cnt == '0) |-> ##(`RISCV_MULDIV_LAT - 1) o_valid);

endmodule

/* src/riscv_stage_regs.sv */
`timescale 1ns/1ps

module riscv_stage_regs (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  riscv_pkg::stage_ctrl_t i_ctrl_d,
  riscv_hzrd_if.stage            hzrd,
  output riscv_pkg::stage_ctrl_t o_ctrl_e,
  output riscv_pkg::stage_ctrl_t o_ctrl_m,
  output riscv_pkg::stage_ctrl_t o_ctrl_w
);

  // D/E where stall wins over flush so a frozen pipe keeps its contents
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      o_ctrl_e <= '0;
    else if (!hzrd.stallde)
    begin
      if (hzrd.flushde)
        o_ctrl_e <= '0;  // bubble
      else
        o_ctrl_e <= i_ctrl_d;
    end
  end

  // E/M
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      o_ctrl_m <= '0;
    else if (!hzrd.stallem)
      o_ctrl_m <= o_ctrl_e;
  end

  // M/W
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      o_ctrl_w <= '0;
    else if (!hzrd.stallmw)
      o_ctrl_w <= o_ctrl_m;
  end

  // stall and flush of D/E only meet while the whole pipe is frozen for mul/div
  a_de_stall_flush: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (hzrd.stallde && hzrd.flushde) |-> (hzrd.stallem && hzrd.stallmw));

endmodule

/* src/riscv_decoder.sv */
`timescale 1ns/1ps

module riscv_decoder (
  input  logic [31:0]            i_instr,
  input  logic                   i_instr_valid,
  output riscv_pkg::stage_ctrl_t o_ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       m_ext;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  assign m_ext  = (funct7 == 7'b0000001);  // M-extension encoding

  always_comb
  begin
    o_ctrl        = '0;
    o_ctrl.opcode = opcode;
    case (opcode)
      riscv_pkg::OPC_LUI:
      begin
        o_ctrl.rd   = i_instr[11:7];  // no source registers
        o_ctrl.regw = 1'b1;
      end
      riscv_pkg::OPC_LOAD:
      begin
        o_ctrl.rs1       = i_instr[19:15];
        o_ctrl.rd        = i_instr[11:7];
        o_ctrl.regw      = 1'b1;
        o_ctrl.resultsrc = riscv_pkg::RES_MEM;
      end
      riscv_pkg::OPC_OP:
      begin
        o_ctrl.rs1    = i_instr[19:15];
        o_ctrl.rs2    = i_instr[24:20];
        o_ctrl.rd     = i_instr[11:7];
        o_ctrl.regw   = 1'b1;
        o_ctrl.mul_en = m_ext && !funct3[2];  // mul, mulh, mulhsu, mulhu
        o_ctrl.div_en = m_ext && funct3[2];   // div, divu, rem, remu
      end
      riscv_pkg::OPC_OPIMM:
      begin
        o_ctrl.rs1  = i_instr[19:15];
        o_ctrl.rd   = i_instr[11:7];
        o_ctrl.regw = 1'b1;
      end
      riscv_pkg::OPC_STORE, riscv_pkg::OPC_BRANCH:
      begin
        o_ctrl.rs1 = i_instr[19:15];  // no destination
        o_ctrl.rs2 = i_instr[24:20];
      end
      default:
        o_ctrl = '0;
    endcase
    if (!i_instr_valid)
      o_ctrl = '0;  // empty slot
  end

endmodule

/* src/riscv_hzrd_if.sv */
`timescale 1ns/1ps

interface riscv_hzrd_if;

  logic stallpc;  // hold fetch pc
  logic stallfd;
  logic flushfd;
  logic flushde;
  logic stallde;
  logic stallem;
  logic stallmw;

  modport ctrl (
    output stallpc,
    output stallfd,
    output flushfd,
    output flushde,
    output stallde,
    output stallem,
    output stallmw
  );

  modport stage (
    input flushde,
    input stallde,
    input stallem,
    input stallmw
  );

endinterface

/* src/riscv_pkg.sv */
`include "riscv_cfg.svh"

package riscv_pkg;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;

  typedef enum logic [1:0] {
    RES_ALU = 2'b00,
    RES_PC  = 2'b01,
    RES_MEM = 2'b10  // load data
  } resultsrc_e;

  typedef enum logic [1:0] {
    FWD_RF     = 2'b00,
    FWD_W      = 2'b01,
    FWD_M_ALU  = 2'b10,
    FWD_M_UIMM = 2'b11  // lui result in memory stage
  } fwdsel_e;

  // all-zero value is the bubble
  typedef struct packed {
    logic [`RISCV_REGADDR_W-1:0] rs1;
    logic [`RISCV_REGADDR_W-1:0] rs2;
    logic [`RISCV_REGADDR_W-1:0] rd;
    logic [6:0]                  opcode;
    logic                        regw;
    resultsrc_e                  resultsrc;
    logic                        mul_en;
    logic                        div_en;
  } stage_ctrl_t;

endpackage

/* src/riscv_cfg.svh */
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// register file address width
`define RISCV_REGADDR_W  5

// operand width
`define RISCV_XLEN       32

// cycles from a mul/div entering execute to its valid
`define RISCV_MULDIV_LAT 4

`endif
